//--- alu.sv
`timescale 1ns/1ns

module alu import rvPkg::*; (
	input  logic [aluOpW-1:0] op,
	input  logic [xlen-1:0]   a,
	input  logic [xlen-1:0]   b,
	output logic [xlen-1:0]   result,
	output logic              zero,
	output logic              lessSigned,
	output logic              lessUnsigned
);

	logic [xlen-1:0] diff;
	logic [4:0]      shamt;

	assign diff  = a - b;
	assign shamt = b[4:0];                       // Upper bits ignored

	// Compare flags for branches and slt
	assign zero         = (diff == '0);
	assign lessSigned   = ($signed(a) < $signed(b));
	assign lessUnsigned = (a < b);

	always_comb begin
		case (op)
			aluAdd:   result = a + b;
			aluSub:   result = diff;
			aluAnd:   result = a & b;
			aluOr:    result = a | b;
			aluXor:   result = a ^ b;
			aluSlt:   result = {{(xlen-1){1'b0}}, lessSigned};
			aluSltu:  result = {{(xlen-1){1'b0}}, lessUnsigned};
			aluSll:   result = a << shamt;
			aluSrl:   result = a >> shamt;
			aluSra:   result = $unsigned($signed(a) >>> shamt);   // Sign fill
			aluPassB: result = b;
			default:  result = '0;
		endcase
	end

endmodule

//--- controlFsm.sv
`timescale 1ns/1ns

module controlFsm import rvPkg::*; (
	input  logic              iCLK,
	input  logic              iRST,
	input  logic              branchTaken,
	input  instrT             instr,
	output logic              irWrite,
	output logic              pcWrite,
	output logic              pcWriteCond,
	output logic              iOrD,
	output logic              regWrite,
	output logic              memRead,
	output logic              memWrite,
	output logic [1:0]        aluSrcA,
	output logic [1:0]        aluSrcB,
	output logic [1:0]        wbSrc,
	output logic [1:0]        pcSrc,
	output logic [aluOpW-1:0] aluOp
);

	// ******************************
	// State codes
	localparam logic [3:0] fetch     = 4'd0;
	localparam logic [3:0] decode    = 4'd1;
	localparam logic [3:0] exeAlu    = 4'd2;
	localparam logic [3:0] exeBranch = 4'd3;
	localparam logic [3:0] exeJal    = 4'd4;
	localparam logic [3:0] exeJalr   = 4'd5;
	localparam logic [3:0] memAddr   = 4'd6;   // Effective address for lw and sw
	localparam logic [3:0] memRd     = 4'd7;
	localparam logic [3:0] memWr     = 4'd8;
	localparam logic [3:0] writeBack = 4'd9;

	logic [3:0]        state;
	logic [3:0]        nextState;
	logic [6:0]        opcode;
	logic              altBit;        // funct7 bit 5
	logic [aluOpW-1:0] funcOp;        // ALU op for OP and OP-IMM

	assign opcode = instr.rType.opcode;
	assign altBit = instr.rType.funct7[5];

	// ******************************
	// State register
	always_ff @(posedge iCLK or posedge iRST) begin
		if (iRST) begin
			state <= fetch;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		case (state)
			fetch:  nextState = decode;
			decode: begin
				case (opcode)
					opOp,
					opOpImm,
					opLui:    nextState = exeAlu;
					opBranch: nextState = exeBranch;
					opJal:    nextState = exeJal;
					opJalr:   nextState = exeJalr;
					opLoad,
					opStore:  nextState = memAddr;
					default:  nextState = fetch;   // Unknown opcode skipped
				endcase
			end
			exeAlu:    nextState = writeBack;
			exeBranch: nextState = fetch;
			exeJal:    nextState = writeBack;
			exeJalr:   nextState = writeBack;
			memAddr:   nextState = (opcode == opLoad) ? memRd : memWr;
			memRd:     nextState = writeBack;
			default:   nextState = fetch;          // memWr, writeBack
		endcase
	end

	// ******************************
	// funct3/funct7 to ALU op
	always_comb begin
		case (instr.rType.funct3)
			f3AddSub: funcOp = (opcode == opOp && altBit) ? aluSub : aluAdd;   // No subi
			f3Sll:    funcOp = aluSll;
			f3Slt:    funcOp = aluSlt;
			f3Sltu:   funcOp = aluSltu;
			f3Xor:    funcOp = aluXor;
			f3SrlSra: funcOp = altBit ? aluSra : aluSrl;   // srai keeps bit 30 too
			f3Or:     funcOp = aluOr;
			default:  funcOp = aluAnd;
		endcase
	end

	// ******************************
	// Per-state control
	always_comb begin
		irWrite     = 1'b0;
		pcWrite     = 1'b0;
		pcWriteCond = 1'b0;
		iOrD        = 1'b0;
		regWrite    = 1'b0;
		memRead     = 1'b0;
		memWrite    = 1'b0;
		aluSrcA     = srcAReg;
		aluSrcB     = srcBReg;
		wbSrc       = wbAluOut;
		pcSrc       = pcFromAlu;
		aluOp       = aluAdd;                       // Address, PC+4 and target sums
		case (state)
			fetch: begin
				memRead = 1'b1;                 // Bus address is PC
				irWrite = 1'b1;
				pcWrite = 1'b1;                 // PC <= PC+4
				aluSrcA = srcAPc;
				aluSrcB = srcBFour;
			end
			decode: begin
				aluSrcA = srcAOldPc;            // Branch/jal target into ALUOut
				aluSrcB = srcBImm;
			end
			exeAlu: begin
				aluSrcB = (opcode == opOp) ? srcBReg : srcBImm;
				aluOp   = (opcode == opLui) ? aluPassB : funcOp;
			end
			exeBranch: begin
				aluOp       = aluSub;           // Compare A with B
				pcWriteCond = 1'b1;             // Qualifies the outcome
				pcWrite     = branchTaken;
				pcSrc       = pcFromOut;        // Target from decode
			end
			exeJal: begin
				aluSrcA = srcAOldPc;            // Keep target in ALUOut
				aluSrcB = srcBImm;
			end
			exeJalr: begin
				aluSrcB = srcBImm;              // rs1 + imm
			end
			memAddr: begin
				aluSrcB = srcBImm;              // I or S immediate by opcode
			end
			memRd: begin
				memRead = 1'b1;
				iOrD    = 1'b1;
			end
			memWr: begin
				memWrite = 1'b1;
				iOrD     = 1'b1;
			end
			writeBack: begin
				regWrite = 1'b1;
				case (opcode)
					opLoad: wbSrc = wbMdr;
					opJal: begin
						wbSrc   = wbPc;         // Link is PC after fetch
						pcWrite = 1'b1;
						pcSrc   = pcFromOut;
					end
					opJalr: begin
						wbSrc   = wbPc;
						pcWrite = 1'b1;
						pcSrc   = pcFromJr;     // A still holds rs1 here
						aluSrcB = srcBImm;
					end
					default: wbSrc = wbAluOut;
				endcase
			end
			default: ;
		endcase
	end

endmodule

//--- cpuBus_assert.sv
`timescale 1ns/1ns

module cpuBusAssert (
	input logic iCLK,
	input logic iRST,
	input logic memRead,
	input logic memWrite,
	input logic irWrite
);

	int failCount = 0;   // Failed assertions so far

	// ******************************
	// Bus and fetch rules
	noReadWrite: assert property (@(posedge iCLK) disable iff (iRST) !(memRead && memWrite))
		else begin
			$error("memRead and memWrite high in the same cycle");
			failCount++;
		end

	quietAfterReset: assert property (@(posedge iCLK) $fell(iRST) |-> !memWrite)
		else begin
			$error("memWrite high in the first cycle after reset");
			failCount++;
		end

	irOnFetch: assert property (@(posedge iCLK) disable iff (iRST) irWrite |-> memRead)
		else begin
			$error("irWrite high without a memory read");   // IR loads only from the bus
			failCount++;
		end

endmodule

bind controlFsm cpuBusAssert busChecks (
	.iCLK(iCLK),
	.iRST(iRST),
	.memRead(memRead),
	.memWrite(memWrite),
	.irWrite(irWrite)
);

//--- cpuTop.sv
`timescale 1ns/1ns

module cpuTop import rvPkg::*; #(
	parameter logic [xlen-1:0] resetPc = 32'h0000_0000   // First fetch address
) (
	input  logic            iCLK,
	input  logic            iRST,
	input  logic [xlen-1:0] memRData,
	output logic            memRead,
	output logic            memWrite,
	output logic [xlen-1:0] memAddr,
	output logic [xlen-1:0] memWData
);

	// ******************************
	// Control lines, FSM to datapath
	logic              irWrite;
	logic              pcWrite;
	logic              pcWriteCond;
	logic              iOrD;
	logic              regWrite;
	logic [1:0]        aluSrcA;
	logic [1:0]        aluSrcB;
	logic [1:0]        wbSrc;
	logic [1:0]        pcSrc;
	logic [aluOpW-1:0] aluOp;

	// Status back to the FSM
	instrT             instr;         // IR contents
	logic              branchTaken;

	// ******************************
	// Sequencer
	controlFsm fsm (.*);   // Port names match the wires above

	// Registers, ALU and bus muxes
	datapath #(
		.resetPc(resetPc)
	) dp (.*);

endmodule

//--- datapath.sv
`timescale 1ns/1ns

module datapath import rvPkg::*; #(
	parameter logic [xlen-1:0] resetPc = 32'h0000_0000
) (
	input  logic              iCLK,
	input  logic              iRST,
	input  logic              irWrite,
	input  logic              pcWrite,
	input  logic              pcWriteCond,
	input  logic              iOrD,
	input  logic              regWrite,
	input  logic              memRead,
	input  logic              memWrite,
	input  logic [1:0]        aluSrcA,
	input  logic [1:0]        aluSrcB,
	input  logic [1:0]        wbSrc,
	input  logic [1:0]        pcSrc,
	input  logic [aluOpW-1:0] aluOp,
	input  logic [xlen-1:0]   memRData,
	output instrT             instr,          // IR
	output logic              branchTaken,
	output logic [xlen-1:0]   memAddr,
	output logic [xlen-1:0]   memWData
);

	// ******************************
	// Registers and internal nets
	logic [xlen-1:0] pc;
	logic [xlen-1:0] oldPc;                  // PC of the instruction in IR
	logic [xlen-1:0] aReg;
	logic [xlen-1:0] bReg;
	logic [xlen-1:0] aluOut;
	logic [xlen-1:0] mdr;
	logic [xlen-1:0] rdData1;
	logic [xlen-1:0] rdData2;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] srcA;
	logic [xlen-1:0] srcB;
	logic [xlen-1:0] aluResult;
	logic [xlen-1:0] wbData;
	logic [xlen-1:0] pcNext;
	logic            zero;
	logic            lessSigned;
	logic            lessUnsigned;
	logic            condMet;

	regFile rf (
		.iCLK(iCLK),
		.iRST(iRST),
		.wrEn(regWrite),
		.rdAddr1(instr.rType.rs1),
		.rdAddr2(instr.rType.rs2),
		.wrAddr(instr.rType.rd),
		.wrData(wbData),
		.rdData1(rdData1),
		.rdData2(rdData2)
	);

	immGen ig (
		.instr(instr),
		.imm(imm)
	);

	alu alu0 (
		.op(aluOp),
		.a(srcA),
		.b(srcB),
		.result(aluResult),
		.zero(zero),
		.lessSigned(lessSigned),
		.lessUnsigned(lessUnsigned)
	);

	// ******************************
	// Muxes
	always_comb begin
		case (aluSrcA)
			srcAPc:    srcA = pc;
			srcAOldPc: srcA = oldPc;
			default:   srcA = aReg;
		endcase
		case (aluSrcB)
			srcBFour: srcB = 32'd4;
			srcBImm:  srcB = imm;
			default:  srcB = bReg;
		endcase
		case (wbSrc)
			wbMdr:   wbData = mdr;
			wbPc:    wbData = pc;            // Already PC+4 since fetch
			default: wbData = aluOut;
		endcase
		case (pcSrc)
			pcFromOut: pcNext = aluOut;
			pcFromJr:  pcNext = {aluResult[xlen-1:1], 1'b0};
			default:   pcNext = aluResult;
		endcase
	end

	assign memAddr  = iOrD ? aluOut : pc;
	assign memWData = memWrite ? bReg : '0;   // Bus data idles at zero

	// Branch outcome from ALU flags
	always_comb begin
		case (instr.bType.funct3)
			f3Beq:   condMet = zero;
			f3Bne:   condMet = !zero;
			f3Blt:   condMet = lessSigned;
			f3Bge:   condMet = !lessSigned;
			f3Bltu:  condMet = lessUnsigned;
			f3Bgeu:  condMet = !lessUnsigned;
			default: condMet = 1'b0;
		endcase
	end

	assign branchTaken = pcWriteCond && condMet;   // Only meaningful in branch execute

	// ******************************
	// PC and IR
	always_ff @(posedge iCLK or posedge iRST) begin
		if (iRST) begin
			pc    <= resetPc;
			instr <= '0;
		end else begin
			if (pcWrite)
				pc <= pcNext;
			if (irWrite)
				instr <= memRData;
		end
	end

	// Operand and result holding registers
	always_ff @(posedge iCLK) begin
		aReg   <= rdData1;
		bReg   <= rdData2;
		aluOut <= aluResult;
		if (irWrite)
			oldPc <= pc;
		if (memRead)
			mdr <= memRData;
	end

endmodule

//--- immGen.sv
`timescale 1ns/1ns

module immGen import rvPkg::*; (
	input  instrT           instr,
	output logic [xlen-1:0] imm
);

	// View picked by opcode
	always_comb begin
		case (instr.rType.opcode)
			opStore: begin
				imm = {{20{instr.sType.imm11to5[6]}},
				       instr.sType.imm11to5, instr.sType.imm4to0};
			end
			opBranch: begin
				imm = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
				       instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};   // Halfword offset
			end
			opLui: begin
				imm = {instr.uType.imm31to12, 12'b0};        // Upper immediate
			end
			opJal: begin
				imm = {{11{instr.jType.imm20}}, instr.jType.imm20, instr.jType.imm19to12,
				       instr.jType.imm11, instr.jType.imm10to1, 1'b0};
			end
			default: begin
				// Loads, jalr and OP-IMM
				imm = {{20{instr.iType.imm11to0[11]}}, instr.iType.imm11to0};
			end
		endcase
	end

endmodule

//--- project.f
rvPkg.sv
alu.sv
immGen.sv
regFile.sv
datapath.sv
controlFsm.sv
cpuTop.sv
cpuBus_assert.sv
tbCpu.sv

//--- regFile.sv
`timescale 1ns/1ns

module regFile import rvPkg::*; (
	input  logic                iCLK,
	input  logic                iRST,
	input  logic                wrEn,
	input  logic [regAddrW-1:0] rdAddr1,
	input  logic [regAddrW-1:0] rdAddr2,
	input  logic [regAddrW-1:0] wrAddr,
	input  logic [xlen-1:0]     wrData,
	output logic [xlen-1:0]     rdData1,
	output logic [xlen-1:0]     rdData2
);

	logic [xlen-1:0] regs [2**regAddrW];   // x0 to x31

	// Single write port
	always_ff @(posedge iCLK or posedge iRST) begin
		if (iRST) begin
			for (int i = 0; i < 2**regAddrW; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAddr != '0)) begin   // x0 never written
			regs[wrAddr] <= wrData;
		end
	end

	// Asynchronous reads
	assign rdData1 = regs[rdAddr1];
	assign rdData2 = regs[rdAddr2];

endmodule

//--- rvPkg.sv
package rvPkg;

	// ******************************
	// Widths
	localparam int xlen     = 32;    // Data and address word
	localparam int regAddrW = 5;     // Register index
	localparam int aluOpW   = 4;     // ALU operation code

	// ******************************
	// Major opcodes
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opOpImm  = 7'b0010011;
	localparam logic [6:0] opOp     = 7'b0110011;
	localparam logic [6:0] opLui    = 7'b0110111;

	// Branch funct3
	localparam logic [2:0] f3Beq  = 3'b000;
	localparam logic [2:0] f3Bne  = 3'b001;
	localparam logic [2:0] f3Blt  = 3'b100;
	localparam logic [2:0] f3Bge  = 3'b101;
	localparam logic [2:0] f3Bltu = 3'b110;
	localparam logic [2:0] f3Bgeu = 3'b111;

	// ALU funct3 with funct7 bit 5 picking sub and sra
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll    = 3'b001;
	localparam logic [2:0] f3Slt    = 3'b010;
	localparam logic [2:0] f3Sltu   = 3'b011;
	localparam logic [2:0] f3Xor    = 3'b100;
	localparam logic [2:0] f3SrlSra = 3'b101;
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;

	// ******************************
	// ALU operation codes
	localparam logic [aluOpW-1:0] aluAdd   = 4'd0;
	localparam logic [aluOpW-1:0] aluSub   = 4'd1;
	localparam logic [aluOpW-1:0] aluAnd   = 4'd2;
	localparam logic [aluOpW-1:0] aluOr    = 4'd3;
	localparam logic [aluOpW-1:0] aluXor   = 4'd4;
	localparam logic [aluOpW-1:0] aluSlt   = 4'd5;
	localparam logic [aluOpW-1:0] aluSltu  = 4'd6;
	localparam logic [aluOpW-1:0] aluSll   = 4'd7;
	localparam logic [aluOpW-1:0] aluSrl   = 4'd8;
	localparam logic [aluOpW-1:0] aluSra   = 4'd9;
	localparam logic [aluOpW-1:0] aluPassB = 4'd10;   // lui goes straight through

	// ******************************
	// Datapath mux selects
	localparam logic [1:0] srcAReg    = 2'd0;   // Register A
	localparam logic [1:0] srcAPc     = 2'd1;   // Current PC
	localparam logic [1:0] srcAOldPc  = 2'd2;   // PC of this instruction
	localparam logic [1:0] srcBReg    = 2'd0;   // Register B
	localparam logic [1:0] srcBFour   = 2'd1;   // Constant 4
	localparam logic [1:0] srcBImm    = 2'd2;   // Immediate
	localparam logic [1:0] wbAluOut   = 2'd0;
	localparam logic [1:0] wbMdr      = 2'd1;
	localparam logic [1:0] wbPc       = 2'd2;   // Link address
	localparam logic [1:0] pcFromAlu  = 2'd0;   // PC+4 in fetch
	localparam logic [1:0] pcFromOut  = 2'd1;   // Branch and jal target
	localparam logic [1:0] pcFromJr   = 2'd2;   // jalr target with bit 0 cleared

	// ******************************
	// Instruction word, one view per format
	typedef union packed {
		struct packed {
			logic [6:0]          funct7;
			logic [regAddrW-1:0] rs2;
			logic [regAddrW-1:0] rs1;
			logic [2:0]          funct3;
			logic [regAddrW-1:0] rd;
			logic [6:0]          opcode;
		} rType;
		struct packed {
			logic [11:0]         imm11to0;
			logic [regAddrW-1:0] rs1;
			logic [2:0]          funct3;
			logic [regAddrW-1:0] rd;
			logic [6:0]          opcode;
		} iType;
		struct packed {
			logic [6:0]          imm11to5;
			logic [regAddrW-1:0] rs2;
			logic [regAddrW-1:0] rs1;
			logic [2:0]          funct3;
			logic [4:0]          imm4to0;
			logic [6:0]          opcode;
		} sType;
		struct packed {
			logic                imm12;
			logic [5:0]          imm10to5;
			logic [regAddrW-1:0] rs2;
			logic [regAddrW-1:0] rs1;
			logic [2:0]          funct3;
			logic [3:0]          imm4to1;
			logic                imm11;
			logic [6:0]          opcode;
		} bType;
		struct packed {
			logic [19:0]         imm31to12;
			logic [regAddrW-1:0] rd;
			logic [6:0]          opcode;
		} uType;
		struct packed {
			logic                imm20;
			logic [9:0]          imm10to1;
			logic                imm11;
			logic [7:0]          imm19to12;
			logic [regAddrW-1:0] rd;
			logic [6:0]          opcode;
		} jType;
	} instrT;

endpackage

//--- tbCpu.sv
`timescale 1ns/1ns

module tbCpu import rvPkg::*; ();

	localparam logic [31:0] startPc  = 32'h0000_0100;   // Program base
	localparam logic [31:0] haltAddr = 32'h0000_0FFC;   // Last word of memory
	localparam int          numTests = 5;

	logic        iCLK;
	logic        iRST;
	logic [31:0] memRData;
	logic        memRead;
	logic        memWrite;
	logic [31:0] memAddr;
	logic [31:0] memWData;

	logic [31:0] mem [1024];                  // DUT memory
	logic [31:0] refMem [1024];               // Reference copy
	logic [31:0] refRegs [32];
	logic [31:0] refPc;
	logic [31:0] refStAddr;                   // Last reference store
	logic [31:0] refStData;
	logic [31:0] asmPc;                       // Program build pointer
	logic [31:0] dataOff;                     // Next result slot off x10
	integer      seed;
	integer      savedSeed;
	int          errors;
	int          checks;
	int          assertFails;
	int          storeCount;
	int          cycles;
	int          cycleLimit;
	int          maxDyn;
	int          dyn;
	int          t;
	logic        running;
	logic        haltSeen;

	cpuTop #(
		.resetPc(startPc)
	) UUT (
		.iCLK(iCLK),
		.iRST(iRST),
		.memRData(memRData),
		.memRead(memRead),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.memWData(memWData)
	);

	always #10 iCLK = ~iCLK;                  // 20 ns period

	// ******************************
	// Memory model
	assign memRData = mem[memAddr[11:2]];     // Same-cycle read data

	always @(posedge iCLK) begin
		if (memWrite)
			mem[memAddr[11:2]] <= memWData;
	end

	// ******************************
	// Instruction encoders
	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, opOp};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};   // sw only
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
	endfunction

	// ******************************
	// Reference model with RV32I semantics
	function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  return alt ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011:  return (a < b) ? 32'd1 : 32'd0;
			3'b100:  return a ^ b;
			3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchModel(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			3'b101:  return $signed(a) >= $signed(b);
			3'b110:  return a < b;
			3'b111:  return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// One instruction that returns 1 on a store
	function automatic logic execInstr();
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] res;
		logic [31:0] ea;
		logic [31:0] nextPc;
		logic        wr;
		logic        isStore;
		ins    = refMem[refPc[11:2]];
		a      = refRegs[ins[19:15]];
		b      = refRegs[ins[24:20]];
		immI   = {{20{ins[31]}}, ins[31:20]};
		immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		nextPc = refPc + 4;
		res    = '0;
		wr     = 1'b0;
		isStore = 1'b0;
		case (ins[6:0])
			opLui: begin
				res = {ins[31:12], 12'b0};
				wr  = 1'b1;
			end
			opOpImm: begin
				res = aluModel(ins[14:12], (ins[14:12] == 3'b101) && ins[30], a, immI);
				wr  = 1'b1;                   // Only srai uses bit 30
			end
			opOp: begin
				res = aluModel(ins[14:12], ins[30], a, b);
				wr  = 1'b1;
			end
			opBranch: begin
				if (branchModel(ins[14:12], a, b))
					nextPc = refPc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			end
			opJal: begin
				res    = refPc + 4;
				wr     = 1'b1;
				nextPc = refPc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			opJalr: begin
				res    = refPc + 4;
				wr     = 1'b1;
				nextPc = (a + immI) & ~32'd1;
			end
			opLoad: begin
				ea  = a + immI;
				res = refMem[ea[11:2]];
				wr  = 1'b1;
			end
			opStore: begin
				refStAddr = a + immS;
				refStData = b;
				refMem[refStAddr[11:2]] = b;
				isStore = 1'b1;
			end
			default: ;
		endcase
		if (wr && ins[11:7] != 5'd0)
			refRegs[ins[11:7]] = res;
		refPc = nextPc;
		return isStore;
	endfunction

	function automatic logic stepToStore();
		int   n;
		logic hit;
		n   = 0;
		hit = 1'b0;
		while (!hit && n < 100000) begin
			hit = execInstr();
			n++;
		end
		return hit;
	endfunction

	// Dynamic instruction count up to the halt store
	function automatic int instrsToHalt();
		int   n;
		logic done;
		n    = 0;
		done = 1'b0;
		while (!done && n < 100000) begin
			if (execInstr() && refStAddr == haltAddr)
				done = 1'b1;
			n++;
		end
		return n;
	endfunction

	task automatic resetModel();
		int i;
		for (i = 0; i < 1024; i++)
			refMem[i] = mem[i];
		for (i = 0; i < 32; i++)
			refRegs[i] = '0;              // Matches DUT reset
		refPc = startPc;
	endtask

	// ******************************
	// Program building
	task automatic emit(input logic [31:0] w);
		mem[asmPc[11:2]] = w;
		asmPc = asmPc + 4;
	endtask

	task automatic loadImm(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] upper;
		upper = (value + 32'h800) >> 12;  // Rounds for the signed addi part
		emit({upper[19:0], rd, opLui});
		emit(encI(value[11:0], rd, 3'b000, rd, opOpImm));
	endtask

	task automatic storeReg(input logic [4:0] rs);
		emit(encS(dataOff[11:0], rs, 5'd10));
		dataOff = dataOff + 4;
	endtask

	// Sum x1 into x3 until the branch falls through
	task automatic countLoop(input logic [2:0] f3, input logic [11:0] start, input logic swap);
		emit(encI(start, 5'd0, 3'b000, 5'd1, opOpImm));
		emit(encR(7'h00, 5'd1, 5'd3, 3'b000, 5'd3));
		emit(encI(12'd1, 5'd1, 3'b000, 5'd1, opOpImm));
		if (swap)
			emit(encB(-13'sd8, 5'd1, 5'd2, f3));   // Limit against counter
		else
			emit(encB(-13'sd8, 5'd2, 5'd1, f3));
		storeReg(5'd3);
	endtask

	task automatic buildProgram(input int num);
		int          i;
		int          lim;
		logic [31:0] r1;
		logic [31:0] r2;
		for (i = 0; i < 1024; i++)
			mem[i] = 32'hC0DE_0000 | (i << 2);   // Fill tracks the address
		asmPc   = startPc;
		dataOff = '0;
		loadImm(5'd10, 32'h800);          // Result area
		loadImm(5'd11, 32'h900);          // Load/store area
		loadImm(5'd12, 32'hA00);          // Copy area
		case (num)
			2: begin
				r1 = $random(seed) & 32'h7FFF_FFFF;   // Positive
				r2 = $random(seed) | 32'h8000_0000;   // Negative
				loadImm(5'd1, r1);
				loadImm(5'd2, r2);
				for (i = 0; i < 8; i++) begin
					emit(encR(7'h00, 5'd2, 5'd1, i[2:0], 5'd3));
					storeReg(5'd3);
				end
				emit(encR(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));   // sub
				storeReg(5'd3);
				emit(encR(7'h20, 5'd1, 5'd2, 3'b101, 5'd3));   // sra of negative
				storeReg(5'd3);
				emit(encR(7'h00, 5'd1, 5'd2, 3'b010, 5'd3));   // slt reversed
				storeReg(5'd3);
				emit(encR(7'h00, 5'd1, 5'd2, 3'b011, 5'd3));   // sltu reversed
				storeReg(5'd3);
				for (i = 0; i < 8; i++) begin
					r1 = $random(seed);
					if (i == 1 || i == 5)
						r1 = r1 & 32'h1F;           // Shift amount only
					emit(encI(r1[11:0], 5'd2, i[2:0], 5'd3, opOpImm));
					storeReg(5'd3);
				end
				emit(encI({7'h20, r1[4:0]}, 5'd2, 3'b101, 5'd3, opOpImm));   // srai
				storeReg(5'd3);
				r2 = $random(seed);
				emit({r2[19:0], 5'd3, opLui});
				storeReg(5'd3);
			end
			3: begin
				lim = 3 + ($random(seed) & 7);
				emit(encI(lim[11:0], 5'd0, 3'b000, 5'd2, opOpImm));
				countLoop(f3Blt, -12'sd3, 1'b0);
				countLoop(f3Bltu, -12'sd3, 1'b0);    // Exits after one pass
				countLoop(f3Bne, 12'd0, 1'b0);
				countLoop(f3Bge, -12'sd3, 1'b1);
				countLoop(f3Bgeu, 12'd0, 1'b1);
				emit(encB(13'd8, 5'd3, 5'd3, f3Beq));   // Taken
				emit(encI(12'd1000, 5'd3, 3'b000, 5'd3, opOpImm));
				emit(encB(13'd8, 5'd0, 5'd2, f3Beq));   // Not taken
				emit(encI(12'd7, 5'd3, 3'b000, 5'd3, opOpImm));
				storeReg(5'd3);
				// Call and return with link values sent to memory
				emit(encJ(21'd12, 5'd6));
				storeReg(5'd6);
				emit(encJ(21'd16, 5'd0));
				emit(encI(12'd5, 5'd3, 3'b000, 5'd3, opOpImm));   // Subroutine body
				emit(encI(12'd1, 5'd6, 3'b000, 5'd7, opJalr));    // Odd target
				emit(encI(12'd999, 5'd3, 3'b000, 5'd3, opOpImm)); // Never run
				storeReg(5'd7);
				storeReg(5'd3);
			end
			4: begin
				for (i = 0; i < 6; i++) begin
					loadImm(5'd1, $random(seed));
					emit(encS(12'(i * 4), 5'd1, 5'd11));
				end
				for (i = 0; i < 6; i++) begin
					emit(encI(12'(i * 4), 5'd11, 3'b010, 5'd2, opLoad));
					emit(encS(12'(i * 4), 5'd2, 5'd12));
				end
			end
			5: begin
				loadImm(5'd1, $random(seed) | 32'd1);   // Never zero
				emit(encI(12'd123, 5'd0, 3'b000, 5'd0, opOpImm));
				storeReg(5'd0);
				r1 = $random(seed);
				emit({r1[19:0], 5'd0, opLui});
				storeReg(5'd0);
				emit(encR(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
				storeReg(5'd0);
				emit(encS(12'd0, 5'd1, 5'd11));
				emit(encI(12'd0, 5'd11, 3'b010, 5'd0, opLoad));
				storeReg(5'd0);
				emit(encJ(21'd4, 5'd0));          // Link dropped
				storeReg(5'd0);
				storeReg(5'd1);
			end
			default: ;
		endcase
		loadImm(5'd31, haltAddr);
		emit(encS(12'd0, 5'd0, 5'd31));       // End marker
		emit(encJ(21'd0, 5'd0));              // Spin
	endtask

	// ******************************
	// Checking
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// Each DUT store against the next reference store
	always @(negedge iCLK) begin
		if (running && memWrite) begin
			storeCount++;
			if (!stepToStore()) begin
				$display("At %0t ns the DUT wrote %h to %h but the reference made no store",
					$time, memWData, memAddr);
				errors++;
			end else begin
				check("memAddr", memAddr, refStAddr);
				check("memWData", memWData, refStData);
			end
			if (memAddr == haltAddr)
				haltSeen = 1'b1;
		end
	end

	// Watchdog
	always @(posedge iCLK) begin
		if (running) begin
			cycles++;
			if (cycles > cycleLimit) begin
				if (storeCount == 0)
					$display("Timeout after %0d cycles, the DUT never stored", cycles);
				else
					$display("Timeout after %0d cycles, no store to the halt address", cycles);
				$display("TESTS FAILED");
				$finish;
			end
		end
	end

	task automatic runTest(input int num, input string name);
		int errBefore;
		int chkBefore;
		@(negedge iCLK);
		errBefore = errors;
		chkBefore = checks;
		iRST    = 1'b1;
		running = 1'b0;
		buildProgram(num);
		resetModel();
		haltSeen   = 1'b0;
		storeCount = 0;
		cycles     = 0;
		repeat (2) @(negedge iCLK);           // Two reset cycles
		iRST    = 1'b0;
		running = 1'b1;
		if (num == 1) begin
			check("memRead", {31'd0, memRead}, 32'd1);   // First fetch
			check("memAddr", memAddr, startPc);
			check("memWrite", {31'd0, memWrite}, 32'd0);
		end
		wait (haltSeen);
		@(negedge iCLK);
		running = 1'b0;
		errors      = errors + UUT.fsm.busChecks.failCount - assertFails;   // Bus assertions
		assertFails = UUT.fsm.busChecks.failCount;
		$display("Test %0d %s: %0d stores, %0d checks, %0d errors", num, name, storeCount,
			checks - chkBefore, errors - errBefore);
	endtask

	// ******************************
	// Main sequence
	initial begin
		iCLK        = 1'b0;
		iRST        = 1'b1;
		running     = 1'b0;
		haltSeen    = 1'b0;
		seed        = 96856;
		errors      = 0;
		checks      = 0;
		assertFails = 0;
		storeCount  = 0;
		cycles      = 0;
		cycleLimit  = 0;
		maxDyn      = 0;
		savedSeed   = seed;
		for (t = 1; t <= numTests; t++) begin   // Longest program sets the limit
			buildProgram(t);
			resetModel();
			dyn = instrsToHalt();
			if (dyn > maxDyn)
				maxDyn = dyn;
		end
		seed       = savedSeed;               // Same programs again
		cycleLimit = 5 * maxDyn + 100;
		runTest(1, "reset fetch");
		runTest(2, "ALU ops");
		runTest(3, "branches and jumps");
		runTest(4, "load and store");
		runTest(5, "x0 writes");
		$display("%0d tests, %0d checks, %0d errors", numTests, checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
